// File: build.f
hdl/tpm_reg_map_pkg.sv
hdl/tpm_fsm_pkg.sv
hdl/tpm_locality_arbiter.sv
hdl/tpm_command_status.sv
hdl/tpm_register_bank.sv
hdl/tpm_reg_space.sv
tb/tpm_reg_space_tb.sv

// File: hdl/tpm_command_status.sv
// Command lifecycle of the FIFO interface; exec_done_i is a level, the write strobes last one cycle
module tpm_command_status
(
	input	logic	clock,
	input	logic	reset_n,

	input	logic	cmd_ready_wr_i,
	input	logic	tpm_go_wr_i,
	input	logic	fifo_wr_i,
	input	logic	seize_abort_i,
	input	logic	exec_done_i,

	output	logic	cmd_ready_o,
	output	logic	data_avail_o,
	output	logic	expect_o,
	output	logic	exec_start_o,
	output	logic	exec_ack_o
);

	tpm_fsm_pkg::sts_state_e	state_q;
	tpm_fsm_pkg::sts_state_e	state_next;

	always_comb
	begin
		state_next = state_q;
		case (state_q)
			tpm_fsm_pkg::STS_IDLE:
				if (cmd_ready_wr_i)
					state_next = tpm_fsm_pkg::STS_READY;
			tpm_fsm_pkg::STS_READY:
				if (fifo_wr_i)
					state_next = tpm_fsm_pkg::STS_RECEPTION;	// First command byte
			tpm_fsm_pkg::STS_RECEPTION:
				if (cmd_ready_wr_i)
					state_next = tpm_fsm_pkg::STS_IDLE;
				else if (tpm_go_wr_i)
					state_next = tpm_fsm_pkg::STS_EXECUTION;
			tpm_fsm_pkg::STS_EXECUTION:
				if (cmd_ready_wr_i)
					state_next = tpm_fsm_pkg::STS_IDLE;
				else if (exec_done_i)
					state_next = tpm_fsm_pkg::STS_COMPLETION;
			tpm_fsm_pkg::STS_COMPLETION:
				if (cmd_ready_wr_i)
					state_next = tpm_fsm_pkg::STS_IDLE;
			default:
				state_next = tpm_fsm_pkg::STS_IDLE;
		endcase

		// A seize drops whatever command was running
		if (seize_abort_i)
			state_next = tpm_fsm_pkg::STS_IDLE;
	end

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
			state_q <= tpm_fsm_pkg::STS_IDLE;
		else
			state_q <= state_next;
	end

	// Flags decoded straight from the state
	assign cmd_ready_o  = state_q == tpm_fsm_pkg::STS_READY;
	assign expect_o     = state_q == tpm_fsm_pkg::STS_RECEPTION;
	assign exec_start_o = state_q == tpm_fsm_pkg::STS_EXECUTION;
	assign data_avail_o = state_q == tpm_fsm_pkg::STS_COMPLETION;
	assign exec_ack_o   = state_q == tpm_fsm_pkg::STS_COMPLETION;

endmodule

// File: hdl/tpm_fsm_pkg.sv
// State encodings and locality number for the arbiter and command status machines
package tpm_fsm_pkg;

	typedef logic [3:0] locality_num_t;	// Address bits 15:12

	// Locality grant machine, one release cycle between grants
	typedef enum logic [1:0]
	{
		LOC_NULL,
		LOC_RELEASE,
		LOC_GRANTED
	} loc_state_e;

	// Command lifecycle
	typedef enum logic [2:0]
	{
		STS_IDLE,
		STS_READY,
		STS_RECEPTION,
		STS_EXECUTION,
		STS_COMPLETION
	} sts_state_e;

endpackage

// File: hdl/tpm_locality_arbiter.sv
// Locality arbiter, NUM_LOCALITIES from 1 to 5; a grant lands two cycles after a request write
module tpm_locality_arbiter
#(
	parameter int NUM_LOCALITIES = 5
)
(
	input	logic				clock,
	input	logic				reset_n,

	input	logic				access_wr_i,
	input	tpm_fsm_pkg::locality_num_t	access_num_i,
	input	tpm_reg_map_pkg::reg_byte_t	access_data_i,

	output	logic				active_valid_o,
	output	tpm_fsm_pkg::locality_num_t	active_num_o,
	output	logic				release_state_o,
	output	logic				loc_changed_o,
	output	logic				seize_abort_o,
	output	logic [NUM_LOCALITIES-1:0]	request_use_o,
	output	logic [NUM_LOCALITIES-1:0]	been_seized_o
);

	localparam tpm_fsm_pkg::locality_num_t LOC_LIMIT =
		tpm_fsm_pkg::locality_num_t'(NUM_LOCALITIES);

	tpm_fsm_pkg::loc_state_e	state_q;
	tpm_fsm_pkg::loc_state_e	state_next;
	tpm_fsm_pkg::locality_num_t	active_num_q;
	tpm_fsm_pkg::locality_num_t	grant_num;
	logic [NUM_LOCALITIES-1:0]	request_use_q;
	logic [NUM_LOCALITIES-1:0]	seize_q;
	logic [NUM_LOCALITIES-1:0]	been_seized_q;
	logic				in_range;
	logic				any_request;
	logic				request_wr;
	logic				relinquish;
	logic				try_seize;
	logic				granting;

	assign in_range    = access_num_i < LOC_LIMIT;
	assign any_request = |request_use_q;
	assign granting    = (state_q == tpm_fsm_pkg::LOC_RELEASE) && any_request;

	assign request_wr = access_wr_i && in_range &&
		(access_data_i[tpm_reg_map_pkg::ACC_REQ_USE_BIT] ||
		access_data_i[tpm_reg_map_pkg::ACC_SEIZE_BIT]);

	assign relinquish = access_wr_i && (state_q == tpm_fsm_pkg::LOC_GRANTED) &&
		(access_num_i == active_num_q) && access_data_i[tpm_reg_map_pkg::ACC_ACTIVE_BIT];

	// Only a higher locality may take over
	assign try_seize = access_wr_i && in_range && (state_q == tpm_fsm_pkg::LOC_GRANTED) &&
		(access_num_i > active_num_q) && access_data_i[tpm_reg_map_pkg::ACC_SEIZE_BIT];

	// Highest requester wins
	always_comb
	begin
		grant_num = '0;
		for (int i = 0; i < NUM_LOCALITIES; i++)
			if (request_use_q[i])
				grant_num = tpm_fsm_pkg::locality_num_t'(i);
	end

	always_comb
	begin
		state_next = state_q;
		case (state_q)
			tpm_fsm_pkg::LOC_NULL:
				if (any_request || request_wr)
					state_next = tpm_fsm_pkg::LOC_RELEASE;
			tpm_fsm_pkg::LOC_RELEASE:
				state_next = any_request ? tpm_fsm_pkg::LOC_GRANTED : tpm_fsm_pkg::LOC_NULL;
			tpm_fsm_pkg::LOC_GRANTED:
				if (relinquish || try_seize)
					state_next = tpm_fsm_pkg::LOC_RELEASE;
			default:
				state_next = tpm_fsm_pkg::LOC_NULL;
		endcase
	end

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state_q       <= tpm_fsm_pkg::LOC_NULL;
			active_num_q  <= '0;
			request_use_q <= '0;
			seize_q       <= '0;
			been_seized_q <= '0;
		end
		else
		begin
			state_q <= state_next;
			if (granting)
				active_num_q <= grant_num;
			for (int i = 0; i < NUM_LOCALITIES; i++)
			begin
				if (granting && grant_num == tpm_fsm_pkg::locality_num_t'(i))
					request_use_q[i] <= 1'b0;
				if (state_q == tpm_fsm_pkg::LOC_RELEASE)
					seize_q[i] <= 1'b0;	// Seize lasts one release cycle
				if (try_seize && active_num_q == tpm_fsm_pkg::locality_num_t'(i))
					been_seized_q[i] <= 1'b1;
				if (access_wr_i && access_num_i == tpm_fsm_pkg::locality_num_t'(i))
				begin
					request_use_q[i] <= request_wr;
					seize_q[i]       <= try_seize;
					if (access_data_i[tpm_reg_map_pkg::ACC_SEIZED_BIT])
						been_seized_q[i] <= 1'b0;
				end
			end
		end
	end

	assign active_valid_o  = state_q == tpm_fsm_pkg::LOC_GRANTED;
	assign active_num_o    = active_num_q;
	assign release_state_o = state_q == tpm_fsm_pkg::LOC_RELEASE;
	assign loc_changed_o   = granting;	// Release that hands over a grant
	assign seize_abort_o   = |seize_q;
	assign request_use_o   = request_use_q;
	assign been_seized_o   = been_seized_q;

endmodule

// File: hdl/tpm_reg_map_pkg.sv
// Register map of the TPM FIFO interface; 12-bit offsets within one locality, single-byte access
package tpm_reg_map_pkg;

	typedef logic [7:0]  reg_byte_t;	// One bus or register byte
	typedef logic [11:0] reg_offset_t;	// Address bits 11:0

	// Register offsets, multi-byte registers give their lowest byte
	localparam reg_offset_t ACCESS_OFS       = 12'h000;
	localparam reg_offset_t INT_ENABLE_OFS   = 12'h008;	// Bytes 008 to 00B
	localparam reg_offset_t INT_STATUS_OFS   = 12'h010;
	localparam reg_offset_t INTF_CAP_OFS     = 12'h014;	// Bytes 014 to 017
	localparam reg_offset_t STS_OFS          = 12'h018;	// Bytes 018 to 01B
	localparam reg_offset_t FIFO_OFS         = 12'h024;	// Four-byte window
	localparam reg_offset_t XFIFO_OFS        = 12'h080;	// Four-byte window
	localparam reg_offset_t INTERFACE_ID_OFS = 12'h030;	// Bytes 030 to 033
	localparam reg_offset_t DID_VID_OFS      = 12'hF00;	// Bytes F00 to F03
	localparam reg_offset_t RID_OFS          = 12'hF04;

	// Access byte fields
	localparam int ACC_VALID_BIT   = 7;
	localparam int ACC_ACTIVE_BIT  = 5;	// Active locality, write 1 to relinquish
	localparam int ACC_SEIZED_BIT  = 4;	// Been seized, write 1 to clear
	localparam int ACC_SEIZE_BIT   = 3;
	localparam int ACC_PENDING_BIT = 2;
	localparam int ACC_REQ_USE_BIT = 1;
	localparam int ACC_ESTAB_BIT   = 0;

	// STS byte 0 fields
	localparam int STS_VALID_BIT      = 7;
	localparam int STS_CMD_READY_BIT  = 6;
	localparam int STS_GO_BIT         = 5;
	localparam int STS_DATA_AVAIL_BIT = 4;
	localparam int STS_EXPECT_BIT     = 3;

	// Interrupt fields, same positions in enable byte 0 and status byte 0
	localparam int INT_GLOBAL_BIT     = 7;	// Enable byte 3 only
	localparam int INT_CMD_READY_BIT  = 7;
	localparam int INT_POLARITY_LSB   = 3;	// Two bits wide
	localparam int INT_LOC_CHANGE_BIT = 2;
	localparam int INT_DATA_AVAIL_BIT = 0;

	// Identity values
	localparam logic [15:0] TPM_DID = 16'h5654;
	localparam logic [15:0] TPM_VID = 16'h3037;
	localparam reg_byte_t   TPM_RID = 8'hFF;

	// Four-byte identity registers, lowest offset in the low byte
	localparam logic [31:0] INTF_CAP_WORD     = 32'h3000_07E9;
	localparam logic [31:0] INTERFACE_ID_WORD = 32'h0000_8100;
	localparam logic [31:0] DID_VID_WORD      = {TPM_DID, TPM_VID};

	localparam reg_byte_t STS_FAMILY_BYTE = 8'h04;	// TPM2.0
	localparam reg_byte_t UNMAPPED_BYTE   = 8'hFF;

endpackage

// File: hdl/tpm_reg_space.sv
// TPM FIFO register space top; one-cycle byte strobes, no FIFO storage, FIFO reads return 0xFF
module tpm_reg_space
#(
	parameter int		NUM_LOCALITIES = 5,		// 1 to 5
	parameter logic [15:0]	BURST_COUNT    = 16'h0064
)
(
	input	logic				clock,
	input	logic				reset_n,

	input	logic				req_i,
	input	logic				dir_i,
	input	logic [15:0]			address_i,
	input	tpm_reg_map_pkg::reg_byte_t	write_data_i,
	input	logic				exec_done_i,

	output	tpm_reg_map_pkg::reg_byte_t	read_data_o,
	output	logic [NUM_LOCALITIES-1:0]	locality_o,
	output	logic				exec_start_o,
	output	logic				exec_ack_o,
	output	logic				pirq_n_o
);

	logic				access_wr;
	tpm_fsm_pkg::locality_num_t	access_num;
	tpm_reg_map_pkg::reg_byte_t	access_data;
	logic				cmd_ready_wr;
	logic				tpm_go_wr;
	logic				fifo_wr;
	logic				active_valid;
	tpm_fsm_pkg::locality_num_t	active_num;
	logic				release_state;
	logic				loc_changed;
	logic				seize_abort;
	logic [NUM_LOCALITIES-1:0]	request_use;
	logic [NUM_LOCALITIES-1:0]	been_seized;
	logic				cmd_ready;
	logic				data_avail;
	logic				cmd_expect;

	tpm_locality_arbiter #(.NUM_LOCALITIES(NUM_LOCALITIES)) u_arbiter
	(
		.clock(clock), .reset_n(reset_n),
		.access_wr_i(access_wr), .access_num_i(access_num), .access_data_i(access_data),
		.active_valid_o(active_valid), .active_num_o(active_num),
		.release_state_o(release_state), .loc_changed_o(loc_changed),
		.seize_abort_o(seize_abort),
		.request_use_o(request_use), .been_seized_o(been_seized)
	);

	tpm_command_status u_command_status
	(
		.clock(clock), .reset_n(reset_n),
		.cmd_ready_wr_i(cmd_ready_wr), .tpm_go_wr_i(tpm_go_wr), .fifo_wr_i(fifo_wr),
		.seize_abort_i(seize_abort), .exec_done_i(exec_done_i),
		.cmd_ready_o(cmd_ready), .data_avail_o(data_avail), .expect_o(cmd_expect),
		.exec_start_o(exec_start_o), .exec_ack_o(exec_ack_o)
	);

	tpm_register_bank #(.NUM_LOCALITIES(NUM_LOCALITIES), .BURST_COUNT(BURST_COUNT)) u_bank
	(
		.clock(clock), .reset_n(reset_n),
		.req_i(req_i), .dir_i(dir_i), .address_i(address_i), .write_data_i(write_data_i),
		.active_valid_i(active_valid), .active_num_i(active_num),
		.release_state_i(release_state), .loc_changed_i(loc_changed),
		.request_use_i(request_use), .been_seized_i(been_seized),
		.cmd_ready_i(cmd_ready), .data_avail_i(data_avail), .expect_i(cmd_expect),
		.read_data_o(read_data_o),
		.access_wr_o(access_wr), .access_num_o(access_num), .access_data_o(access_data),
		.cmd_ready_wr_o(cmd_ready_wr), .tpm_go_wr_o(tpm_go_wr), .fifo_wr_o(fifo_wr),
		.locality_o(locality_o), .pirq_n_o(pirq_n_o)
	);

endmodule

// File: hdl/tpm_register_bank.sv
// Register bank for single-byte strobes; non-access registers answer only the active locality
module tpm_register_bank
#(
	parameter int		NUM_LOCALITIES = 5,
	parameter logic [15:0]	BURST_COUNT    = 16'h0064
)
(
	input	logic				clock,
	input	logic				reset_n,

	input	logic				req_i,
	input	logic				dir_i,		// 1 read, 0 write
	input	logic [15:0]			address_i,
	input	tpm_reg_map_pkg::reg_byte_t	write_data_i,

	input	logic				active_valid_i,
	input	tpm_fsm_pkg::locality_num_t	active_num_i,
	input	logic				release_state_i,
	input	logic				loc_changed_i,
	input	logic [NUM_LOCALITIES-1:0]	request_use_i,
	input	logic [NUM_LOCALITIES-1:0]	been_seized_i,
	input	logic				cmd_ready_i,
	input	logic				data_avail_i,
	input	logic				expect_i,

	output	tpm_reg_map_pkg::reg_byte_t	read_data_o,
	output	logic				access_wr_o,
	output	tpm_fsm_pkg::locality_num_t	access_num_o,
	output	tpm_reg_map_pkg::reg_byte_t	access_data_o,
	output	logic				cmd_ready_wr_o,
	output	logic				tpm_go_wr_o,
	output	logic				fifo_wr_o,
	output	logic [NUM_LOCALITIES-1:0]	locality_o,
	output	logic				pirq_n_o
);

	localparam tpm_fsm_pkg::locality_num_t LOC_LIMIT =
		tpm_fsm_pkg::locality_num_t'(NUM_LOCALITIES);

	tpm_reg_map_pkg::reg_offset_t	offset;
	tpm_fsm_pkg::locality_num_t	loc_num;
	logic [9:0]			word;
	logic [1:0]			byte_sel;
	logic				wr;
	logic				rd;
	logic				is_access;
	logic				allow;
	logic				reg_wr;
	logic				sts_wr;
	logic				loc_in_range;
	logic				addr_seized;
	logic				addr_request;

	logic		global_en;
	logic		cmd_ready_en;
	logic [1:0]	polarity;
	logic		loc_change_en;
	logic		data_avail_en;
	logic		cmd_ready_int;
	logic		loc_change_int;
	logic		data_avail_int;
	logic		cmd_ready_q;
	logic		data_avail_q;

	tpm_reg_map_pkg::reg_byte_t	status_clear;
	tpm_reg_map_pkg::reg_byte_t	access_byte;
	tpm_reg_map_pkg::reg_byte_t	sts_byte;
	tpm_reg_map_pkg::reg_byte_t	int_enable_byte;
	tpm_reg_map_pkg::reg_byte_t	int_status_byte;
	tpm_reg_map_pkg::reg_byte_t	rd_byte;
	tpm_reg_map_pkg::reg_byte_t	read_data_q;

	assign offset       = address_i[11:0];
	assign loc_num      = address_i[15:12];
	assign word         = offset[11:2];
	assign byte_sel     = offset[1:0];
	assign wr           = req_i && !dir_i;
	assign rd           = req_i && dir_i;
	assign is_access    = offset == tpm_reg_map_pkg::ACCESS_OFS;
	assign loc_in_range = loc_num < LOC_LIMIT;
	assign allow        = active_valid_i && (loc_num == active_num_i);
	assign reg_wr       = wr && allow;
	assign sts_wr       = reg_wr && (offset == tpm_reg_map_pkg::STS_OFS);

	// Strobes to the arbiter and the status machine
	assign access_wr_o    = wr && is_access;	// Any locality
	assign access_num_o   = loc_num;
	assign access_data_o  = write_data_i;
	assign cmd_ready_wr_o = sts_wr && write_data_i[tpm_reg_map_pkg::STS_CMD_READY_BIT];
	assign tpm_go_wr_o    = sts_wr && write_data_i[tpm_reg_map_pkg::STS_GO_BIT];
	assign fifo_wr_o      = reg_wr &&
		(word == tpm_reg_map_pkg::FIFO_OFS[11:2] || word == tpm_reg_map_pkg::XFIFO_OFS[11:2]);

	assign status_clear = (reg_wr && offset == tpm_reg_map_pkg::INT_STATUS_OFS) ?
		write_data_i : '0;	// Write one to clear

	// Per-locality flags of the addressed locality, and the one-hot grant
	always_comb
	begin
		addr_seized  = 1'b0;
		addr_request = 1'b0;
		for (int i = 0; i < NUM_LOCALITIES; i++)
		begin
			locality_o[i] = active_valid_i && active_num_i == tpm_fsm_pkg::locality_num_t'(i);
			if (loc_num == tpm_fsm_pkg::locality_num_t'(i))
			begin
				addr_seized  = been_seized_i[i];
				addr_request = request_use_i[i];
			end
		end
	end

	// Field packing
	always_comb
	begin
		access_byte = '0;
		access_byte[tpm_reg_map_pkg::ACC_VALID_BIT]   = !release_state_i;
		access_byte[tpm_reg_map_pkg::ACC_ACTIVE_BIT]  = allow;
		access_byte[tpm_reg_map_pkg::ACC_SEIZED_BIT]  = addr_seized;
		access_byte[tpm_reg_map_pkg::ACC_PENDING_BIT] = |request_use_i;
		access_byte[tpm_reg_map_pkg::ACC_REQ_USE_BIT] = addr_request;
		access_byte[tpm_reg_map_pkg::ACC_ESTAB_BIT]   = 1'b1;

		sts_byte = '0;
		sts_byte[tpm_reg_map_pkg::STS_VALID_BIT]      = 1'b1;
		sts_byte[tpm_reg_map_pkg::STS_CMD_READY_BIT]  = cmd_ready_i;
		sts_byte[tpm_reg_map_pkg::STS_DATA_AVAIL_BIT] = data_avail_i;
		sts_byte[tpm_reg_map_pkg::STS_EXPECT_BIT]     = expect_i;

		int_enable_byte = '0;
		int_enable_byte[tpm_reg_map_pkg::INT_CMD_READY_BIT]       = cmd_ready_en;
		int_enable_byte[tpm_reg_map_pkg::INT_POLARITY_LSB +: 2]   = polarity;
		int_enable_byte[tpm_reg_map_pkg::INT_LOC_CHANGE_BIT]      = loc_change_en;
		int_enable_byte[tpm_reg_map_pkg::INT_DATA_AVAIL_BIT]      = data_avail_en;

		int_status_byte = '0;
		int_status_byte[tpm_reg_map_pkg::INT_CMD_READY_BIT]  = cmd_ready_int;
		int_status_byte[tpm_reg_map_pkg::INT_LOC_CHANGE_BIT] = loc_change_int;
		int_status_byte[tpm_reg_map_pkg::INT_DATA_AVAIL_BIT] = data_avail_int;
	end

	// Read multiplexer, FIFO windows fall through to 0xFF
	always_comb
	begin
		rd_byte = tpm_reg_map_pkg::UNMAPPED_BYTE;
		if (is_access)
		begin
			if (loc_in_range)
				rd_byte = access_byte;
		end
		else if (allow)
		begin
			case (word)
				tpm_reg_map_pkg::INT_ENABLE_OFS[11:2]:
					if (byte_sel == 2'd0)
						rd_byte = int_enable_byte;
					else if (byte_sel == 2'd3)
						rd_byte = {global_en, 7'd0};
					else
						rd_byte = 8'h00;
				tpm_reg_map_pkg::INT_STATUS_OFS[11:2]:
					rd_byte = (byte_sel == 2'd0) ? int_status_byte : 8'h00;
				tpm_reg_map_pkg::INTF_CAP_OFS[11:2]:
					rd_byte = tpm_reg_map_pkg::INTF_CAP_WORD[{byte_sel, 3'b000} +: 8];
				tpm_reg_map_pkg::STS_OFS[11:2]:
					case (byte_sel)
						2'd0:    rd_byte = sts_byte;
						2'd1:    rd_byte = BURST_COUNT[7:0];
						2'd2:    rd_byte = BURST_COUNT[15:8];
						default: rd_byte = tpm_reg_map_pkg::STS_FAMILY_BYTE;
					endcase
				tpm_reg_map_pkg::INTERFACE_ID_OFS[11:2]:
					rd_byte = tpm_reg_map_pkg::INTERFACE_ID_WORD[{byte_sel, 3'b000} +: 8];
				tpm_reg_map_pkg::DID_VID_OFS[11:2]:
					rd_byte = tpm_reg_map_pkg::DID_VID_WORD[{byte_sel, 3'b000} +: 8];
				tpm_reg_map_pkg::RID_OFS[11:2]:
					if (byte_sel == 2'd0)
						rd_byte = tpm_reg_map_pkg::TPM_RID;
				default:
					rd_byte = tpm_reg_map_pkg::UNMAPPED_BYTE;
			endcase
		end
	end

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			global_en      <= 1'b0;
			cmd_ready_en   <= 1'b0;
			polarity       <= 2'b01;	// Level low
			loc_change_en  <= 1'b0;
			data_avail_en  <= 1'b0;
			cmd_ready_int  <= 1'b0;
			loc_change_int <= 1'b0;
			data_avail_int <= 1'b0;
			cmd_ready_q    <= 1'b0;
			data_avail_q   <= 1'b0;
			read_data_q    <= tpm_reg_map_pkg::UNMAPPED_BYTE;
		end
		else
		begin
			cmd_ready_q  <= cmd_ready_i;
			data_avail_q <= data_avail_i;
			read_data_q  <= rd ? rd_byte : tpm_reg_map_pkg::UNMAPPED_BYTE;

			if (reg_wr && offset == tpm_reg_map_pkg::INT_ENABLE_OFS)
			begin
				cmd_ready_en  <= write_data_i[tpm_reg_map_pkg::INT_CMD_READY_BIT];
				polarity      <= write_data_i[tpm_reg_map_pkg::INT_POLARITY_LSB +: 2];
				loc_change_en <= write_data_i[tpm_reg_map_pkg::INT_LOC_CHANGE_BIT];
				data_avail_en <= write_data_i[tpm_reg_map_pkg::INT_DATA_AVAIL_BIT];
			end
			if (reg_wr && offset == tpm_reg_map_pkg::INT_ENABLE_OFS + 12'd3)
				global_en <= write_data_i[tpm_reg_map_pkg::INT_GLOBAL_BIT];

			// New events win over a clear in the same cycle
			cmd_ready_int <= (cmd_ready_int &&
				!status_clear[tpm_reg_map_pkg::INT_CMD_READY_BIT]) ||
				(global_en && cmd_ready_en && cmd_ready_i && !cmd_ready_q);
			data_avail_int <= (data_avail_int &&
				!status_clear[tpm_reg_map_pkg::INT_DATA_AVAIL_BIT]) ||
				(global_en && data_avail_en && data_avail_i && !data_avail_q);
			loc_change_int <= (loc_change_int &&
				!status_clear[tpm_reg_map_pkg::INT_LOC_CHANGE_BIT]) ||
				(global_en && loc_change_en && loc_changed_i);
		end
	end

	assign read_data_o = read_data_q;
	assign pirq_n_o    = !(cmd_ready_int || loc_change_int || data_avail_int);

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, then decide pass or fail from the log

verilator --binary --timing --assert --top-module tpm_reg_space_tb -f build.f \
	-o tpm_reg_space_sim || { echo "Verilator build failed"; exit 1; }

./obj_dir/tpm_reg_space_sim > sim.log 2>&1 || echo "Simulator returned a failing status"
cat sim.log

grep -q "Finished with errors" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Finished with no errors" sim.log && { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation ended without a result"; exit 1; }

// File: tb/tpm_reg_space_tb.sv
// Self-checking testbench for five localities; build with --timing and --assert so the checks run
module tpm_reg_space_tb;

	localparam int CLK_PERIOD     = 20;
	localparam int CYCLES_PER_ROW = 4;	// Strobe cycle plus three settle cycles
	localparam int NUM_LOC        = 5;

	typedef struct packed
	{
		logic		dir;		// 1 read, 0 write
		logic [15:0]	addr;
		logic [7:0]	data;
		logic		done;		// exec_done_i level while the row runs
		logic [7:0]	exp_read;
		logic		check_read;
		logic [4:0]	exp_loc;
		logic		exp_start;
		logic		exp_ack;
		logic		exp_pirq;
	} row_t;

	logic			clock;
	logic			reset_n;
	logic			req_i;
	logic			dir_i;
	logic [15:0]		address_i;
	logic [7:0]		write_data_i;
	logic			exec_done_i;
	logic [7:0]		read_data_o;
	logic [NUM_LOC-1:0]	locality_o;
	logic			exec_start_o;
	logic			exec_ack_o;
	logic			pirq_n_o;

	row_t		rows[$];
	logic		table_ready = 1'b0;
	logic [31:0]	rand_state  = 32'h9088_e32f;
	int		errors      = 0;
	int		checks      = 0;

	// Output levels expected after the rows queued next
	logic [4:0]	lvl_loc;
	logic		lvl_start;
	logic		lvl_ack;
	logic		lvl_pirq;

	tpm_reg_space #(.NUM_LOCALITIES(NUM_LOC), .BURST_COUNT(16'h0064)) u_dut
	(
		.clock(clock), .reset_n(reset_n),
		.req_i(req_i), .dir_i(dir_i), .address_i(address_i),
		.write_data_i(write_data_i), .exec_done_i(exec_done_i),
		.read_data_o(read_data_o), .locality_o(locality_o),
		.exec_start_o(exec_start_o), .exec_ack_o(exec_ack_o), .pirq_n_o(pirq_n_o)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#(CLK_PERIOD / 2) clock = ~clock;
	end

	function automatic logic [31:0] next_random(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic set_levels(input logic [4:0] loc, input logic start, input logic ack,
		input logic pirq);
		lvl_loc   = loc;
		lvl_start = start;
		lvl_ack   = ack;
		lvl_pirq  = pirq;
	endtask

	task automatic queue_row(input logic dir, input logic [15:0] addr, input logic [7:0] data,
		input logic done, input logic [7:0] expected);
		row_t row;
		row.dir        = dir;
		row.addr       = addr;
		row.data       = data;
		row.done       = done;
		row.exp_read   = expected;
		row.check_read = dir;	// Writes only check levels
		row.exp_loc    = lvl_loc;
		row.exp_start  = lvl_start;
		row.exp_ack    = lvl_ack;
		row.exp_pirq   = lvl_pirq;
		rows.push_back(row);
	endtask

	task automatic queue_write(input logic [15:0] addr, input logic [7:0] data, input logic done);
		queue_row(1'b0, addr, data, done, 8'hFF);
	endtask

	task automatic queue_read(input logic [15:0] addr, input logic [7:0] expected,
		input logic done);
		queue_row(1'b1, addr, 8'h00, done, expected);
	endtask

	task automatic compare_value(input string what, input int index, input logic [15:0] got,
		input logic [15:0] expected);
		checks++;
		assert (got === expected)
		else
		begin
			$display("Fail %0t: row %0d %s is %h, expected %h", $time, index, what, got,
				expected);
			errors++;
		end
	endtask

	task automatic build_table();
		logic [11:0] ofs;

		set_levels(5'h00, 1'b0, 1'b0, 1'b1);
		queue_read(16'h0000, 8'h81, 1'b0);	// Access register out of reset
		queue_read(16'h0018, 8'hFF, 1'b0);	// No locality granted yet

		// Locality 3 first, locality 1 queued behind it
		set_levels(5'h08, 1'b0, 1'b0, 1'b1);
		queue_write(16'h3000, 8'h02, 1'b0);
		queue_write(16'h1000, 8'h02, 1'b0);
		queue_read(16'h3000, 8'hA5, 1'b0);	// Active, another request pending
		queue_read(16'h3F00, 8'h37, 1'b0);	// VID low byte
		queue_read(16'h3F03, 8'h56, 1'b0);	// DID high byte
		queue_read(16'h3F04, 8'hFF, 1'b0);
		queue_read(16'h3014, 8'hE9, 1'b0);
		queue_read(16'h3017, 8'h30, 1'b0);
		queue_read(16'h3019, 8'h64, 1'b0);	// Burst count low byte
		queue_read(16'h301B, 8'h04, 1'b0);
		queue_read(16'h3031, 8'h81, 1'b0);
		queue_read(16'h1F00, 8'hFF, 1'b0);	// Locality 1 is gated
		queue_read(16'h1014, 8'hFF, 1'b0);
		queue_read(16'h1000, 8'h87, 1'b0);

		// Relinquish hands over to locality 1, which starts a command
		set_levels(5'h02, 1'b0, 1'b0, 1'b1);
		queue_write(16'h3000, 8'h20, 1'b0);
		queue_read(16'h1000, 8'hA1, 1'b0);
		queue_write(16'h1018, 8'h40, 1'b0);
		queue_read(16'h1018, 8'hC0, 1'b0);

		set_levels(5'h10, 1'b0, 1'b0, 1'b1);
		queue_write(16'h4000, 8'h08, 1'b0);	// Seize by locality 4
		queue_read(16'h1000, 8'h91, 1'b0);
		queue_write(16'h1000, 8'h10, 1'b0);	// Clear beenSeized
		queue_read(16'h1000, 8'h81, 1'b0);
		queue_read(16'h4018, 8'h80, 1'b0);	// Command dropped to Idle

		// Full command lifecycle
		queue_write(16'h4018, 8'h40, 1'b0);
		queue_read(16'h4018, 8'hC0, 1'b0);
		queue_write(16'h4024, 8'hAA, 1'b0);
		queue_read(16'h4018, 8'h88, 1'b0);
		set_levels(5'h10, 1'b1, 1'b0, 1'b1);
		queue_write(16'h4018, 8'h20, 1'b0);
		queue_read(16'h4024, 8'hFF, 1'b0);	// FIFO carries no data
		set_levels(5'h10, 1'b0, 1'b1, 1'b1);
		queue_read(16'h4030, 8'h00, 1'b1);
		queue_read(16'h4018, 8'h90, 1'b1);
		set_levels(5'h10, 1'b0, 1'b0, 1'b1);
		queue_write(16'h4018, 8'h40, 1'b0);
		queue_read(16'h4018, 8'h80, 1'b0);

		// Interrupts on commandReady and dataAvail
		queue_write(16'h4008, 8'h81, 1'b0);
		queue_write(16'h400B, 8'h80, 1'b0);	// Global enable
		queue_read(16'h4008, 8'h81, 1'b0);
		set_levels(5'h10, 1'b0, 1'b0, 1'b0);
		queue_write(16'h4018, 8'h40, 1'b0);
		queue_write(16'h4024, 8'h11, 1'b0);
		set_levels(5'h10, 1'b1, 1'b0, 1'b0);
		queue_write(16'h4018, 8'h20, 1'b0);
		set_levels(5'h10, 1'b0, 1'b1, 1'b0);
		queue_read(16'h4030, 8'h00, 1'b1);
		queue_read(16'h4010, 8'h81, 1'b1);
		set_levels(5'h10, 1'b0, 1'b1, 1'b1);
		queue_write(16'h4010, 8'h81, 1'b1);	// Write one to clear
		queue_read(16'h4010, 8'h00, 1'b1);
		set_levels(5'h10, 1'b0, 1'b0, 1'b1);
		queue_write(16'h4018, 8'h40, 1'b0);

		// Unmapped offsets, XFIFO window skipped
		for (int n = 0; n < 16; n++)
		begin
			do
			begin
				rand_state = next_random(rand_state);
				ofs = 12'h040 + 12'(rand_state % 32'h0000_0EC0);
			end
			while (ofs >= 12'h080 && ofs <= 12'h083);
			rand_state = next_random(rand_state);
			queue_write({4'h4, ofs}, rand_state[7:0], 1'b0);
			queue_read({4'h4, ofs}, 8'hFF, 1'b0);
		end

		queue_read(16'h4000, 8'hA1, 1'b0);
		queue_read(16'h4018, 8'h80, 1'b0);
		queue_read(16'h4008, 8'h81, 1'b0);
		queue_read(16'h400B, 8'h80, 1'b0);
		queue_read(16'h4010, 8'h00, 1'b0);
	endtask

	initial
	begin
		row_t		row;
		logic [7:0]	got_read;

		reset_n      = 1'b0;
		req_i        = 1'b0;
		dir_i        = 1'b0;
		address_i    = 16'h0000;
		write_data_i = 8'h00;
		exec_done_i  = 1'b0;
		build_table();
		table_ready = 1'b1;

		repeat (8) @(posedge clock);
		#2;
		reset_n = 1'b1;
		compare_value("read_data_o after reset", -1, 16'(read_data_o), 16'h00FF);

		for (int r = 0; r < rows.size(); r++)
		begin
			row = rows[r];
			@(posedge clock);
			#2;
			req_i        = 1'b1;
			dir_i        = row.dir;
			address_i    = row.addr;
			write_data_i = row.data;
			exec_done_i  = row.done;
			@(posedge clock);
			#2;
			req_i    = 1'b0;
			got_read = read_data_o;	// Valid only right after the strobe edge
			@(posedge clock);
			@(posedge clock);
			#2;
			if (row.check_read)
				compare_value("read_data_o", r, 16'(got_read), 16'(row.exp_read));
			compare_value("locality_o", r, 16'(locality_o), 16'(row.exp_loc));
			compare_value("exec_start_o", r, 16'(exec_start_o), 16'(row.exp_start));
			compare_value("exec_ack_o", r, 16'(exec_ack_o), 16'(row.exp_ack));
			compare_value("pirq_n_o", r, 16'(pirq_n_o), 16'(row.exp_pirq));
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Twice the expected run time
	initial
	begin
		wait (table_ready);
		#(2 * rows.size() * CYCLES_PER_ROW * CLK_PERIOD);
		$display("Timeout: the table did not finish in the allowed time");
		$display("Finished with errors");
		$finish;
	end

endmodule
